//--- acBlocks.sv
`timescale 1ns/1ps
`include "apr_cfg.svh"

module acBlocks (
  input  logic              clk,
  input  logic              reset,
  input  logic              loadAcBlocks,
  input  logic              loadVmaContext,
  input  logic              vmaPrevEn,
  input  logic              xrPrevious,
  input  aprPkg::ebusWord   ebusData,
  input  aprPkg::acNum      ac,
  input  aprPkg::acNum      xr,
  input  aprPkg::acNum      vmaLow,
  input  aprPkg::magicField magic,
  input  aprPkg::fmSource   fmSel,
  aprStatusIf.blockSrc      status
);
  import aprPkg::*;

  acBlock currentBlock;
  acBlock prevBlock;
  acBlock vmaBlock;
  acBlock xrBlock;
  acBlock magicBlock;
  acNum magicLow;
  acNum acPlus1;
  acNum acPlus2;
  acNum acPlus3;
  acNum acPlusMagic;
  acNum fmAdr;
  acBlock fmBlk;

  // Block registers loaded from the EBUS, previous block follows current
  always_ff @(posedge clk) begin
    if (reset) begin
      currentBlock <= '0;
      prevBlock <= '0;
    end else if (loadAcBlocks) begin
      currentBlock <= ebusData[`APR_BLOCK_BIT0 +: `APR_BLOCK_WIDTH];
      prevBlock <= ebusData[`APR_BLOCK_BIT0 + `APR_BLOCK_WIDTH +: `APR_BLOCK_WIDTH];
    end
  end

  // VMA context captures one of the two blocks
  always_ff @(posedge clk) begin
    if (reset) begin
      vmaBlock <= '0;
    end else if (loadVmaContext) begin
      vmaBlock <= vmaPrevEn ? prevBlock : currentBlock;
    end
  end

  assign magicLow = magic[5:8];
  assign magicBlock = magic[2:4];
  assign xrBlock = xrPrevious ? prevBlock : currentBlock;

  // Four-bit adders, carry out dropped
  assign acPlus1 = ac + acNum'(1);
  assign acPlus2 = ac + acNum'(2);
  assign acPlus3 = ac + acNum'(3);
  assign acPlusMagic = ac + magicLow;

  always_comb begin
    fmBlk = currentBlock;
    case (fmSel)
      3'd0: fmAdr = ac;
      3'd1: fmAdr = acPlus1;
      3'd2: begin
        fmAdr = xr;
        fmBlk = xrBlock;
      end
      3'd3: begin
        fmAdr = vmaLow;
        fmBlk = vmaBlock;
      end
      3'd4: fmAdr = acPlus2;
      3'd5: fmAdr = acPlus3;
      3'd6: fmAdr = acPlusMagic;
      default: begin
        // Absolute location straight from microcode
        fmAdr = magicLow;
        fmBlk = magicBlock;
      end
    endcase
  end

  assign status.currentBlock = currentBlock;
  assign status.prevBlock = prevBlock;
  assign status.fmAdr = fmAdr;
  assign status.fmBlk = fmBlk;

endmodule

//--- aprFlags.sv
`timescale 1ns/1ps
`include "apr_cfg.svh"

module aprFlags (
  input  logic            clk,
  input  logic            reset,
  input  aprPkg::ebusWord ebusData,
  input  logic            selSet,
  input  logic            selClr,
  input  logic            selEn,
  input  logic            selDis,
  input  aprPkg::flagVec  events,
  aprStatusIf.flagSrc     status,
  output logic            aprInterrupt,
  output logic            anyEboxErr
);
  import aprPkg::*;

  flagVec strobeData;
  flagVec flagReg;
  flagVec flagNext;
  flagVec enableReg;
  flagVec enableNext;

  // Data bits that qualify the strobes, one per flag
  assign strobeData = ebusData[`APR_FLAG_BIT0 +: `APR_FLAG_COUNT];

  always_comb begin
    flagNext = flagReg;
    enableNext = enableReg;
    for (int i = 0; i < `APR_FLAG_COUNT; i++) begin
      // Event has priority over a clear in the same cycle
      if (events[i] || (selSet && strobeData[i])) begin
        flagNext[i] = 1'b1;
      end else if (selClr && strobeData[i]) begin
        flagNext[i] = 1'b0;
      end

      // Enable wins when both strobes hit the same bit
      if (selEn && strobeData[i]) begin
        enableNext[i] = 1'b1;
      end else if (selDis && strobeData[i]) begin
        enableNext[i] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flagReg <= '0;
      enableReg <= '0;
    end else begin
      flagReg <= flagNext;
      enableReg <= enableNext;
    end
  end

  // Memory-side errors summarized on the same edge that sets the flag
  always_ff @(posedge clk) begin
    if (reset) begin
      anyEboxErr <= 1'b0;
    end else begin
      anyEboxErr <= flagNext[nxmErr] | flagNext[mbParErr] | flagNext[sAdrParErr];
    end
  end

  // Masked request straight from the registers
  assign aprInterrupt = |(flagReg & enableReg);

  assign status.flags = flagReg;
  assign status.enables = enableReg;

endmodule

//--- aprPatterns.txt
# ebus strb(set clr en dis) events ctl(ldAc ldVma vmaPrev xrPrev) ac xr vmaLow magic fmSel diag(rd func)
# then expected: aprInterrupt anyEboxErr fmAdr fmBlk ebusOut, all hex, checked after the clock edge
000000000 0 00 0 0 0 0 000 0 8 0 0 0 0 000000000
000000000 0 00 0 0 0 0 000 0 9 0 0 0 0 000000000
000000000 0 00 0 0 0 0 000 0 A 0 0 0 0 000000000
028000000 8 00 0 0 0 0 000 0 8 0 0 0 0 028000000
010000000 8 00 0 0 0 0 000 0 8 0 1 0 0 038000000
020000000 4 00 0 0 0 0 000 0 8 0 1 0 0 018000000
008000000 4 20 0 0 0 0 000 0 8 0 1 0 0 018000000
010000000 4 00 0 0 0 0 000 0 8 0 0 0 0 008000000
000000000 0 01 0 0 0 0 000 0 8 0 0 0 0 008400000
03FC00000 4 00 0 0 0 0 000 0 8 0 0 0 0 000000000
020800000 2 00 0 0 0 0 000 0 9 0 0 0 0 020800000
008000000 8 00 0 0 0 0 000 0 8 0 0 0 0 008000000
000000000 0 02 0 0 0 0 000 0 8 1 0 0 0 008800000
000800000 1 00 0 0 0 0 000 0 9 0 0 0 0 020000000
000800000 3 00 0 0 0 0 000 0 9 1 0 0 0 020800000
000800000 4 00 0 0 0 0 000 0 8 0 0 0 0 008000000
000000000 0 10 0 0 0 0 000 0 8 0 1 0 0 00C000000
004000000 4 00 0 0 0 0 000 0 8 0 0 0 0 008000000
000000000 0 04 0 0 0 0 000 0 8 0 1 0 0 009000000
020000000 8 00 0 0 0 0 000 0 8 1 1 0 0 029000000
03FC00000 5 00 0 0 0 0 000 0 9 0 0 0 0 000000000
02B000000 0 00 8 0 0 0 000 0 A 0 0 0 5 02B000000
000000000 0 00 4 0 0 9 000 3 A 0 0 9 5 02B000000
000000000 0 00 6 0 0 9 000 3 B 0 0 9 3 01C800000
017000000 0 00 8 0 0 9 000 3 A 0 0 9 3 017000000
000000000 0 00 0 E 0 0 000 0 B 0 0 E 2 017000000
000000000 0 00 0 F 0 0 000 1 0 0 0 0 2 000000000
000000000 0 00 0 0 A 0 000 2 0 0 0 A 2 000000000
000000000 0 00 1 0 A 0 000 2 B 0 0 A 7 03D000000
000000000 0 00 0 0 0 4 000 3 0 0 0 4 3 000000000
000000000 0 00 0 E 0 0 000 4 0 0 0 0 2 000000000
000000000 0 00 0 E 0 0 000 5 0 0 0 1 2 000000000
000000000 0 00 0 9 0 0 05C 6 0 0 0 5 2 000000000
000000000 0 00 0 0 0 0 05C 7 B 0 0 C 5 02E000000
000000000 0 00 0 0 0 0 1F3 7 0 0 0 3 7 000000000
000000000 0 00 0 0 0 0 000 0 C 0 0 0 2 000000000

//--- aprPkg.sv
`include "apr_cfg.svh"

package aprPkg;

  // Big-endian numbering as on the EBUS, bit 0 is the MSB
  typedef logic [0:`APR_EBUS_WIDTH-1] ebusWord;

  // Index i here matches flagIndex and EBUS bit 6+i
  typedef logic [0:`APR_FLAG_COUNT-1] flagVec;

  // AC number, also the fast memory address
  typedef logic [`APR_AC_WIDTH-1:0] acNum;

  typedef logic [`APR_BLOCK_WIDTH-1:0] acBlock;

  // Bits 2..4 block field, bits 5..8 low four bits
  typedef logic [0:`APR_MAGIC_WIDTH-1] magicField;

  // Fast memory address source code
  typedef logic [`APR_FMSEL_WIDTH-1:0] fmSource;

  typedef enum logic [2:0] {
    sbusErr    = 3'd0,
    nxmErr     = 3'd1,
    ioPfErr    = 3'd2,
    mbParErr   = 3'd3,
    cDirParErr = 3'd4,
    sAdrParErr = 3'd5,
    pwrFail    = 3'd6,
    sweepDone  = 3'd7
  } flagIndex;

endpackage

//--- aprStatusIf.sv
`timescale 1ns/1ps

interface aprStatusIf;
  import aprPkg::*;

  // Flag block state
  flagVec flags;
  flagVec enables;

  // AC block state and the selected fast memory location
  acBlock currentBlock;
  acBlock prevBlock;
  acNum fmAdr;
  acBlock fmBlk;

  modport flagSrc(
    output flags,
    output enables
  );

  modport blockSrc(
    output currentBlock,
    output prevBlock,
    output fmAdr,
    output fmBlk
  );

  modport reader(
    input flags,
    input enables,
    input currentBlock,
    input prevBlock,
    input fmAdr,
    input fmBlk
  );

endinterface

//--- aprTb.sv
`timescale 1ns/1ps
`include "apr_cfg.svh"

module aprTb;
  import aprPkg::*;

  localparam int ClockPeriod = 20;
  localparam int ResetCycles = 10;
  localparam int RandomCycles = 200;
  localparam int MarginCycles = 50;

  logic clk = 1'b0;
  logic reset;
  ebusWord ebusData;
  logic selSet;
  logic selClr;
  logic selEn;
  logic selDis;
  flagVec events;
  logic loadAcBlocks;
  logic loadVmaContext;
  logic vmaPrevEn;
  logic xrPrevious;
  acNum ac;
  acNum xr;
  acNum vmaLow;
  magicField magic;
  fmSource fmSel;
  logic diagRead;
  logic [2:0] diagFunc;
  logic aprInterrupt;
  logic anyEboxErr;
  ebusWord ebusOut;
  acNum fmAdr;
  acBlock fmBlk;

  string rows[$];
  longint unsigned timeLimit = 0;

  // Reference state for the random phase
  flagVec modelFlags;
  flagVec modelEnables;

  aprTop UUT (.*);

  always #(ClockPeriod / 2) clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Run aborted");
  endtask

  task automatic checkValue(input string name, input logic [35:0] actual,
                            input logic [35:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Output check failed");
    end
  endtask

  task automatic driveIdle();
    ebusData = '0;
    {selSet, selClr, selEn, selDis} = 4'h0;
    events = '0;
    {loadAcBlocks, loadVmaContext, vmaPrevEn, xrPrevious} = 4'h0;
    ac = '0;
    xr = '0;
    vmaLow = '0;
    magic = '0;
    fmSel = '0;
    diagRead = 1'b0;
    diagFunc = 3'd0;
  endtask

  task automatic applyReset();
    @(negedge clk);
    reset = 1'b1;
    driveIdle();
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    modelFlags = '0;
    modelEnables = '0;
  endtask

  // Every flag set and enabled, so the next reset has state to clear
  task automatic setAllFlags();
    @(negedge clk);
    ebusData = '0;
    ebusData[`APR_FLAG_BIT0 +: `APR_FLAG_COUNT] = '1;
    {selSet, selClr, selEn, selDis} = 4'hA;
    events = '0;
    diagRead = 1'b1;
    diagFunc = 3'd0;
    @(posedge clk);
    #5;
    checkValue("aprInterrupt", 36'(aprInterrupt), 36'(1'b1));
    checkValue("anyEboxErr", 36'(anyEboxErr), 36'(1'b1));
    checkValue("ebusOut", ebusOut, 36'h03FC00000);
  endtask

  // Flags, enables, blocks and VMA context all read back as zero
  task automatic checkCleared();
    @(negedge clk);
    fmSel = 3'd3;
    #5;
    checkValue("aprInterrupt", 36'(aprInterrupt), 36'd0);
    checkValue("anyEboxErr", 36'(anyEboxErr), 36'd0);
    checkValue("fmAdr", 36'(fmAdr), 36'd0);
    checkValue("fmBlk", 36'(fmBlk), 36'd0);
    for (int f = 0; f < 4; f++) begin
      @(negedge clk);
      diagRead = 1'b1;
      diagFunc = 3'(f);
      #5;
      checkValue("ebusOut", ebusOut, 36'd0);
    end
    @(negedge clk);
    driveIdle();
  endtask

  task automatic loadPatterns();
    int fd;
    string line;
    fd = $fopen("aprPatterns.txt", "r");
    if (fd == 0) begin
      abortRun("Could not open aprPatterns.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        rows.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  task automatic runRow(input string line);
    int count;
    logic [35:0] rowEbus;
    logic [3:0] rowStrb;
    logic [7:0] rowEvents;
    logic [3:0] rowCtl;
    logic [3:0] rowAc;
    logic [3:0] rowXr;
    logic [3:0] rowVma;
    logic [8:0] rowMagic;
    logic [2:0] rowFmSel;
    logic [3:0] rowDiag;
    logic expInt;
    logic expErr;
    logic [3:0] expAdr;
    logic [2:0] expBlk;
    logic [35:0] expEbus;
    count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    rowEbus, rowStrb, rowEvents, rowCtl, rowAc, rowXr, rowVma, rowMagic,
                    rowFmSel, rowDiag, expInt, expErr, expAdr, expBlk, expEbus);
    if (count != 15) begin
      abortRun($sformatf("Pattern row has %0d fields instead of 15: %s", count, line));
    end
    @(negedge clk);
    ebusData = rowEbus;
    {selSet, selClr, selEn, selDis} = rowStrb;
    events = rowEvents;
    {loadAcBlocks, loadVmaContext, vmaPrevEn, xrPrevious} = rowCtl;
    ac = rowAc;
    xr = rowXr;
    vmaLow = rowVma;
    magic = rowMagic;
    fmSel = rowFmSel;
    {diagRead, diagFunc} = rowDiag;
    @(posedge clk);
    #5;
    checkValue("aprInterrupt", 36'(aprInterrupt), 36'(expInt));
    checkValue("anyEboxErr", 36'(anyEboxErr), 36'(expErr));
    checkValue("fmAdr", 36'(fmAdr), 36'(expAdr));
    checkValue("fmBlk", 36'(fmBlk), 36'(expBlk));
    checkValue("ebusOut", ebusOut, expEbus);
  endtask

  // Flag i qualified by its own data bit, event beats clear, enable beats disable
  task automatic updateModel(input logic [3:0] strb, input flagVec d, input flagVec evt);
    for (int i = 0; i < `APR_FLAG_COUNT; i++) begin
      if (evt[i] || (strb[3] && d[i])) begin
        modelFlags[i] = 1'b1;
      end else if (strb[2] && d[i]) begin
        modelFlags[i] = 1'b0;
      end
      if (strb[1] && d[i]) begin
        modelEnables[i] = 1'b1;
      end else if (strb[0] && d[i]) begin
        modelEnables[i] = 1'b0;
      end
    end
  endtask

  task automatic randomCycle();
    logic [31:0] r1;
    logic [31:0] r2;
    flagVec dataBits;
    flagVec evt;
    logic [3:0] strb;
    logic doRead;
    logic [2:0] func;
    logic expErr;
    ebusWord expWord;
    r1 = $urandom();
    r2 = $urandom();
    dataBits = r1[7:0];
    // Sparse events so clears get a chance
    evt = r1[15:8] & r2[15:8] & r2[23:16];
    strb = r1[19:16];
    doRead = r1[20];
    func = r2[2:0];
    @(negedge clk);
    ebusData = '0;
    ebusData[`APR_FLAG_BIT0 +: `APR_FLAG_COUNT] = dataBits;
    {selSet, selClr, selEn, selDis} = strb;
    events = evt;
    diagRead = doRead;
    diagFunc = func;
    updateModel(strb, dataBits, evt);
    expErr = modelFlags[nxmErr] | modelFlags[mbParErr] | modelFlags[sAdrParErr];
    expWord = '0;
    if (doRead && func == 3'd0) begin
      expWord[`APR_FLAG_BIT0 +: `APR_FLAG_COUNT] = modelFlags;
    end else if (doRead && func == 3'd1) begin
      expWord[`APR_FLAG_BIT0 +: `APR_FLAG_COUNT] = modelEnables;
    end
    @(posedge clk);
    #5;
    checkValue("aprInterrupt", 36'(aprInterrupt), 36'(|(modelFlags & modelEnables)));
    checkValue("anyEboxErr", 36'(anyEboxErr), 36'(expErr));
    checkValue("ebusOut", ebusOut, expWord);
  endtask

  initial begin
    void'($urandom(32'h742b));
    reset = 1'b1;
    driveIdle();
    loadPatterns();
    timeLimit = longint'(rows.size() + RandomCycles + 2 * ResetCycles + MarginCycles) *
                ClockPeriod;
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    foreach (rows[k]) begin
      runRow(rows[k]);
    end
    setAllFlags();
    applyReset();
    checkCleared();
    repeat (RandomCycles) randomCycle();
    @(negedge clk);
    if (UUT.flagUnit.chkInst.failCount != 0) begin
      $display("Bound assertions failed %0d times", UUT.flagUnit.chkInst.failCount);
      $display("** FAIL **");
      $fatal(1, "Assertion failures");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

  initial begin
    wait (timeLimit != 0);
    #(timeLimit);
    $display("Timeout: the run did not finish within %0d ns", timeLimit);
    $display("** FAIL **");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- aprTop.sv
`timescale 1ns/1ps

module aprTop (
  input  logic              clk,
  input  logic              reset,
  input  aprPkg::ebusWord   ebusData,
  input  logic              selSet,
  input  logic              selClr,
  input  logic              selEn,
  input  logic              selDis,
  input  aprPkg::flagVec    events,
  input  logic              loadAcBlocks,
  input  logic              loadVmaContext,
  input  logic              vmaPrevEn,
  input  logic              xrPrevious,
  input  aprPkg::acNum      ac,
  input  aprPkg::acNum      xr,
  input  aprPkg::acNum      vmaLow,
  input  aprPkg::magicField magic,
  input  aprPkg::fmSource   fmSel,
  input  logic              diagRead,
  input  logic [2:0]        diagFunc,
  output logic              aprInterrupt,
  output logic              anyEboxErr,
  output aprPkg::ebusWord   ebusOut,
  output aprPkg::acNum      fmAdr,
  output aprPkg::acBlock    fmBlk
);

  aprStatusIf statusBus();

  aprFlags flagUnit (
    .clk(clk),
    .reset(reset),
    .ebusData(ebusData),
    .selSet(selSet),
    .selClr(selClr),
    .selEn(selEn),
    .selDis(selDis),
    .events(events),
    .status(statusBus.flagSrc),
    .aprInterrupt(aprInterrupt),
    .anyEboxErr(anyEboxErr)
  );

  acBlocks blockUnit (
    .clk(clk),
    .reset(reset),
    .loadAcBlocks(loadAcBlocks),
    .loadVmaContext(loadVmaContext),
    .vmaPrevEn(vmaPrevEn),
    .xrPrevious(xrPrevious),
    .ebusData(ebusData),
    .ac(ac),
    .xr(xr),
    .vmaLow(vmaLow),
    .magic(magic),
    .fmSel(fmSel),
    .status(statusBus.blockSrc)
  );

  diagRead diagUnit (
    .diagRead(diagRead),
    .diagFunc(diagFunc),
    .status(statusBus.reader),
    .ebusOut(ebusOut)
  );

  // Fast memory location also goes out to the RAM side
  assign fmAdr = statusBus.fmAdr;
  assign fmBlk = statusBus.fmBlk;

endmodule

//--- apr_cfg.svh
`ifndef APR_CFG_SVH
`define APR_CFG_SVH

// EBUS data word, PDP-10 bit numbering 0..35
`define APR_EBUS_WIDTH 36

// Error and event flags, flag i on EBUS bit APR_FLAG_BIT0+i
`define APR_FLAG_COUNT 8
`define APR_FLAG_BIT0 6

// Current block at this bit, previous block right after it
`define APR_BLOCK_BIT0 6

`define APR_AC_WIDTH 4
`define APR_BLOCK_WIDTH 3

// Microcode magic number and fast memory source select
`define APR_MAGIC_WIDTH 9
`define APR_FMSEL_WIDTH 3

`endif

//--- apr_chk.sv
`timescale 1ns/1ps
`include "apr_cfg.svh"

module apr_chk (
  input logic           clk,
  input logic           reset,
  input aprPkg::flagVec flags,
  input aprPkg::flagVec enables,
  input aprPkg::flagVec events,
  input aprPkg::flagVec strobeData,
  input logic           selSet,
  input logic           selEn,
  input logic           aprInterrupt,
  input logic           anyEboxErr
);
  import aprPkg::*;

  int unsigned resetFails = 0;
  int unsigned interruptFails = 0;
  int unsigned eventFails = 0;
  int unsigned failCount;

  // Bits that can be set or enabled after the coming edge
  flagVec mayBeSet;
  flagVec mayBeEnabled;

  assign failCount = resetFails + interruptFails + eventFails;

  assign mayBeSet = flags | events | (strobeData & {`APR_FLAG_COUNT{selSet}});
  assign mayBeEnabled = enables | (strobeData & {`APR_FLAG_COUNT{selEn}});

  // Whole flag block is idle after a reset edge
  resetClears: assert property (@(posedge clk)
    reset |=> (!aprInterrupt && !anyEboxErr && flags == '0 && enables == '0))
    else begin
      $error("Reset left flag block state or outputs set");
      resetFails++;
    end

  // A request needs a flag and its enable that could both be set last cycle
  interruptNeedsSource: assert property (@(posedge clk) disable iff (reset)
    aprInterrupt |-> $past((mayBeSet & mayBeEnabled) != '0))
    else begin
      $error("Interrupt high with no enabled flag set");
      interruptFails++;
    end

  // An event always lands, whatever the strobes do
  eventSetsFlag: assert property (@(posedge clk) disable iff (reset)
    (events != '0) |=> ((flags & $past(events)) == $past(events)))
    else begin
      $error("Event bit did not set its flag");
      eventFails++;
    end

endmodule

bind aprFlags apr_chk chkInst (
  .clk(clk),
  .reset(reset),
  .flags(flagReg),
  .enables(enableReg),
  .events(events),
  .strobeData(strobeData),
  .selSet(selSet),
  .selEn(selEn),
  .aprInterrupt(aprInterrupt),
  .anyEboxErr(anyEboxErr)
);

//--- diagRead.sv
`timescale 1ns/1ps
`include "apr_cfg.svh"

module diagRead (
  input  logic            diagRead,
  input  logic [2:0]      diagFunc,
  aprStatusIf.reader      status,
  output aprPkg::ebusWord ebusOut
);

  always_comb begin
    ebusOut = '0;
    if (diagRead) begin
      case (diagFunc)
        3'd0: begin
          ebusOut[`APR_FLAG_BIT0 +: `APR_FLAG_COUNT] = status.flags;
        end
        3'd1: begin
          ebusOut[`APR_FLAG_BIT0 +: `APR_FLAG_COUNT] = status.enables;
        end
        3'd2: begin
          // Same layout as the block load word
          ebusOut[`APR_BLOCK_BIT0 +: 2 * `APR_BLOCK_WIDTH] =
            {status.currentBlock, status.prevBlock};
        end
        3'd3: begin
          ebusOut[`APR_BLOCK_BIT0 +: `APR_BLOCK_WIDTH + `APR_AC_WIDTH] =
            {status.fmBlk, status.fmAdr};
        end
        default: begin
          // Unused functions read as zero
          ebusOut = '0;
        end
      endcase
    end
  end

endmodule

//--- runSim.sh
#!/bin/bash
# Build and run the APR status testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --timing --assert --top-module aprTb -f vlog.f -o aprSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/aprSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "\*\* FAIL \*\*" "$LOG"; then
  echo "Testbench reported a failure"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- vlog.f
+incdir+.
aprPkg.sv
aprStatusIf.sv
aprFlags.sv
acBlocks.sv
diagRead.sv
aprTop.sv
apr_chk.sv
aprTb.sv
